/* bus_pkg.sv */
package bus_pkg;

    // word bus geometry
    localparam int data_width = 32;   // address and data
    localparam int sel_width  = 4;    // byte lanes per word

    // only full-word accesses are supported
    localparam logic [sel_width-1:0] sel_all = '1;

    // kind of access latched by the bridge
    typedef enum logic [1:0] {
        cmd_none  = 2'b00,
        cmd_read  = 2'b01,
        cmd_write = 2'b10
    } bus_cmd_t;

    // byte offset bits below the word index
    localparam int byte_off_width = $clog2(sel_width);

endpackage

/* mem_req_pkg.sv */
package mem_req_pkg;

    // request unit controller states
    typedef enum logic [1:0] {
        idle       = 2'b00,
        mem_write  = 2'b01,
        mem_read   = 2'b10,
        instr_read = 2'b11
    } req_state_t;

    // default memory geometry
    localparam int mem_depth_default   = 16;  // words
    localparam int mem_latency_default = 3;   // read cycles after enable

endpackage

/* bus_if.sv */
`timescale 1ns/100ps

// one single-word access between request unit and bridge
interface bus_if import bus_pkg::*; ();

    logic                  read;   // one-cycle strobe
    logic                  write;  // one-cycle strobe
    logic [data_width-1:0] adr;    // byte address, registered
    logic [data_width-1:0] dat_w;  // write data, registered
    logic [sel_width-1:0]  sel;    // byte lanes
    logic [data_width-1:0] dat_r;  // returned word
    logic                  busy;   // access in progress

    // request side
    modport producer (
        output read, write, adr, dat_w, sel,
        input  dat_r, busy
    );

    // bridge side
    modport buffer (
        input  read, write, adr, dat_w, sel,
        output dat_r, busy
    );

endinterface

/* request_unit.sv */
`timescale 1ns/100ps

module request_unit import bus_pkg::*; import mem_req_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    // cpu side
    input  logic                  memread_i,
    input  logic                  memwrite_i,
    input  logic [data_width-1:0] data_to_write_i,
    input  logic [data_width-1:0] instruction_address_i,  // pc
    input  logic [data_width-1:0] data_address_i,         // alu result
    output logic [data_width-1:0] instruction_o,
    output logic [data_width-1:0] data_read_o,
    output logic                  i_hit_o,
    output logic                  d_hit_o,
    // bus side
    bus_if.producer               bus
);

    req_state_t            state;
    req_state_t            next_state;
    logic [data_width-1:0] req_adr;   // address for the access being issued
    logic                  done;      // bridge released this cycle

    assign done = (state != idle) && !bus.busy;

    // fixed priority: store, load, fetch
    always_comb begin
        next_state = state;
        bus.read   = 1'b0;
        bus.write  = 1'b0;
        req_adr    = data_address_i;
        case (state)
            idle: begin
                if (memwrite_i && !d_hit_o) begin
                    bus.write  = 1'b1;
                    next_state = mem_write;
                end else if (memread_i && !d_hit_o) begin
                    bus.read   = 1'b1;
                    next_state = mem_read;
                end else if (!i_hit_o && !d_hit_o) begin
                    // fetch waits out the data hit cycle so a held load goes first
                    bus.read   = 1'b1;
                    req_adr    = instruction_address_i;
                    next_state = instr_read;
                end
            end
            default: begin
                if (!bus.busy) begin
                    next_state = idle;  // back to idle with the hit
                end
            end
        endcase
    end

    // controller and cpu results
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state         <= idle;
            i_hit_o       <= 1'b0;
            d_hit_o       <= 1'b0;
            instruction_o <= '0;
            data_read_o   <= '0;
        end else begin
            state   <= next_state;
            i_hit_o <= done && (state == instr_read);
            d_hit_o <= done && (state == mem_read || state == mem_write);
            if (done && state == instr_read) begin
                instruction_o <= bus.dat_r;
            end
            if (done && state == mem_read) begin
                data_read_o <= bus.dat_r;
            end
        end
    end

    // address and data held until busy falls
    always_ff @(posedge clk) begin
        if (bus.read || bus.write) begin
            bus.adr   <= req_adr;
            bus.dat_w <= data_to_write_i;
            bus.sel   <= sel_all;  // full words only
        end
    end

    // one strobe kind at a time
    a_one_strobe : assert property (
        @(posedge clk) disable iff (rst)
        !(bus.read && bus.write)
    ) else $error("read and write strobes high together");

    // bridge must be free when a strobe is raised
    a_strobe_not_busy : assert property (
        @(posedge clk) disable iff (rst)
        (bus.read || bus.write) |-> !bus.busy
    ) else $error("strobe raised while bridge busy");

endmodule

/* bus_bridge.sv */
`timescale 1ns/100ps

module bus_bridge import bus_pkg::*; #(
    parameter  int MEM_DEPTH   = mem_req_pkg::mem_depth_default,
    parameter  int MEM_LATENCY = mem_req_pkg::mem_latency_default,
    localparam int ADDR_W      = (MEM_DEPTH > 1) ? $clog2(MEM_DEPTH) : 1
) (
    input  logic                  clk,
    input  logic                  rst,
    bus_if.buffer                 bus,
    // memory side
    output logic                  mem_en_o,
    output logic                  mem_we_o,
    output logic [ADDR_W-1:0]     mem_addr_o,
    output logic [data_width-1:0] mem_wdata_o,
    input  logic [data_width-1:0] mem_rdata_i,
    input  logic                  mem_rvalid_i
);

    bus_cmd_t              cmd_q;     // latched access kind
    logic                  issue_q;   // enable goes out the cycle after the strobe
    logic [data_width-1:0] dat_r_q;   // last returned word
    logic                  pending;

    assign pending = (cmd_q != cmd_none);

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            cmd_q   <= cmd_none;
            issue_q <= 1'b0;
        end else begin
            issue_q <= bus.read || bus.write;
            if (bus.write) begin
                cmd_q <= cmd_write;
            end else if (bus.read) begin
                cmd_q <= cmd_read;
            end else if (mem_rvalid_i) begin
                cmd_q <= cmd_none;  // access complete
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mem_rvalid_i) begin
            dat_r_q <= mem_rdata_i;
        end
    end

    // busy drops in the rvalid cycle so the producer can register the word there
    assign bus.busy  = pending && !mem_rvalid_i;
    assign bus.dat_r = mem_rvalid_i ? mem_rdata_i : dat_r_q;

    // adr and dat_w are valid from the cycle after the strobe
    assign mem_en_o    = issue_q;
    assign mem_we_o    = issue_q && (cmd_q == cmd_write) && (bus.sel == sel_all);
    assign mem_addr_o  = bus.adr[byte_off_width +: ADDR_W];  // word index
    assign mem_wdata_o = bus.dat_w;

    // release only after the memory answered
    a_busy_after_rvalid : assert property (
        @(posedge clk) disable iff (rst)
        $fell(pending) |-> $past(mem_rvalid_i)
    ) else $error("busy released without rvalid");

    a_no_stray_rvalid : assert property (
        @(posedge clk) disable iff (rst)
        mem_rvalid_i |-> pending
    ) else $error("rvalid with no pending command");

    // memory answers at its fixed latency
    a_mem_latency : assert property (
        @(posedge clk) disable iff (rst)
        mem_en_o |-> ##MEM_LATENCY mem_rvalid_i
    ) else $error("memory response latency mismatch");

endmodule

/* word_sram.sv */
`timescale 1ns/100ps

module word_sram import bus_pkg::*; import mem_req_pkg::*; #(
    parameter  int MEM_DEPTH   = mem_depth_default,
    parameter  int MEM_LATENCY = mem_latency_default,
    parameter      INIT_FILE   = "mem_init.hex",
    localparam int ADDR_W      = (MEM_DEPTH > 1) ? $clog2(MEM_DEPTH) : 1
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  en_i,
    input  logic                  we_i,
    input  logic [ADDR_W-1:0]     addr_i,
    input  logic [data_width-1:0] wdata_i,
    output logic [data_width-1:0] rdata_o,
    output logic                  rvalid_o
);

    logic [data_width-1:0] mem [MEM_DEPTH];
    logic [MEM_LATENCY-1:0] valid_q;               // one bit per stage
    logic [data_width-1:0]  data_q [MEM_LATENCY];

    initial begin
        $readmemh(INIT_FILE, mem);
    end

    // write lands at the enable; a write returns the stored word
    always_ff @(posedge clk) begin
        if (en_i && we_i) begin
            mem[addr_i] <= wdata_i;
        end
        data_q[0] <= we_i ? wdata_i : mem[addr_i];
        for (int i = 1; i < MEM_LATENCY; i++) begin
            data_q[i] <= data_q[i-1];
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            valid_q <= '0;
        end else begin
            valid_q[0] <= en_i;
            for (int i = 1; i < MEM_LATENCY; i++) begin
                valid_q[i] <= valid_q[i-1];
            end
        end
    end

    assign rdata_o  = data_q[MEM_LATENCY-1];
    assign rvalid_o = valid_q[MEM_LATENCY-1];

endmodule

/* mem_subsys_top.sv */
`timescale 1ns/100ps

module mem_subsys_top import bus_pkg::*; #(
    parameter  int MEM_DEPTH   = mem_req_pkg::mem_depth_default,
    parameter  int MEM_LATENCY = mem_req_pkg::mem_latency_default,
    localparam int ADDR_W      = (MEM_DEPTH > 1) ? $clog2(MEM_DEPTH) : 1
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  memread_i,
    input  logic                  memwrite_i,
    input  logic [data_width-1:0] data_to_write_i,
    input  logic [data_width-1:0] instruction_address_i,
    input  logic [data_width-1:0] data_address_i,
    output logic [data_width-1:0] instruction_o,
    output logic [data_width-1:0] data_read_o,
    output logic                  i_hit_o,
    output logic                  d_hit_o
);

    // memory port between bridge and sram
    logic                  mem_en;
    logic                  mem_we;
    logic [ADDR_W-1:0]     mem_addr;
    logic [data_width-1:0] mem_wdata;
    logic [data_width-1:0] mem_rdata;
    logic                  mem_rvalid;

    bus_if bus ();

    request_unit u_request_unit (
        .clk                   (clk),
        .rst                   (rst),
        .memread_i             (memread_i),
        .memwrite_i            (memwrite_i),
        .data_to_write_i       (data_to_write_i),
        .instruction_address_i (instruction_address_i),
        .data_address_i        (data_address_i),
        .instruction_o         (instruction_o),
        .data_read_o           (data_read_o),
        .i_hit_o               (i_hit_o),
        .d_hit_o               (d_hit_o),
        .bus                   (bus.producer)
    );

    bus_bridge #(
        .MEM_DEPTH   (MEM_DEPTH),
        .MEM_LATENCY (MEM_LATENCY)
    ) u_bus_bridge (
        .clk          (clk),
        .rst          (rst),
        .bus          (bus.buffer),
        .mem_en_o     (mem_en),
        .mem_we_o     (mem_we),
        .mem_addr_o   (mem_addr),
        .mem_wdata_o  (mem_wdata),
        .mem_rdata_i  (mem_rdata),
        .mem_rvalid_i (mem_rvalid)
    );

    word_sram #(
        .MEM_DEPTH   (MEM_DEPTH),
        .MEM_LATENCY (MEM_LATENCY)
    ) u_word_sram (
        .clk      (clk),
        .rst      (rst),
        .en_i     (mem_en),
        .we_i     (mem_we),
        .addr_i   (mem_addr),
        .wdata_i  (mem_wdata),
        .rdata_o  (mem_rdata),
        .rvalid_o (mem_rvalid)
    );

endmodule

/* tb_mem_subsys.sv */
`timescale 1ns/100ps

module tb_mem_subsys import bus_pkg::*; ();

    localparam int MEM_DEPTH   = 16;
    localparam int MEM_LATENCY = 3;
    localparam int MAX_ROWS    = 32;
    localparam int RESET_CYCLES = 8;

    logic                  clk;
    logic                  rst;
    logic                  memread;
    logic                  memwrite;
    logic [data_width-1:0] data_to_write;
    logic [data_width-1:0] instruction_address;
    logic [data_width-1:0] data_address;
    logic [data_width-1:0] instruction;
    logic [data_width-1:0] data_read;
    logic                  i_hit;
    logic                  d_hit;

    // stimulus table, one access per row
    logic                  row_rd      [MAX_ROWS];
    logic                  row_wr      [MAX_ROWS];
    logic [data_width-1:0] row_daddr   [MAX_ROWS];  // byte address
    logic [data_width-1:0] row_wdata   [MAX_ROWS];
    logic [data_width-1:0] row_iaddr   [MAX_ROWS];  // byte address
    logic [data_width-1:0] row_exp     [MAX_ROWS];
    logic                  row_on_data [MAX_ROWS];  // result on data_read_o
    int                    n_rows;

    logic [data_width-1:0] shadow [MEM_DEPTH];  // expected memory contents
    logic [data_width-1:0] build_data;          // data_read_o after the last row built
    int                    seed = 5803;
    int                    cycles = 0;
    int                    cycle_limit = 0;

    mem_subsys_top #(
        .MEM_DEPTH   (MEM_DEPTH),
        .MEM_LATENCY (MEM_LATENCY)
    ) dut (
        .clk                   (clk),
        .rst                   (rst),
        .memread_i             (memread),
        .memwrite_i            (memwrite),
        .data_to_write_i       (data_to_write),
        .instruction_address_i (instruction_address),
        .data_address_i        (data_address),
        .instruction_o         (instruction),
        .data_read_o           (data_read),
        .i_hit_o               (i_hit),
        .d_hit_o               (d_hit)
    );

    always #2 clk = ~clk;  // 4 ns period

    // word i of the preload image
    function automatic logic [data_width-1:0] preload_word(input int i);
        return 32'hA500_0000 + i;
    endfunction

    task automatic fail_now(input string what);
        $display("%s", what);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_word(input string name, input logic [data_width-1:0] expected,
                              input logic [data_width-1:0] actual);
        assert (actual === expected) else begin
            fail_now($sformatf("mismatch at %0t: %s expected %h got %h",
                               $time, name, expected, actual));
        end
    endtask

    // one row; store wins over load, load over fetch
    task automatic add_row(input logic rd, input logic wr, input int dword, input int iword);
        logic [data_width-1:0] wdata;
        wdata = wr ? $random(seed) : '0;
        row_rd[n_rows]    = rd;
        row_wr[n_rows]    = wr;
        row_daddr[n_rows] = dword * 4;
        row_iaddr[n_rows] = iword * 4;
        row_wdata[n_rows] = wdata;
        if (wr) begin
            shadow[dword]       = wdata;
            row_exp[n_rows]     = build_data;  // store leaves data_read_o alone
            row_on_data[n_rows] = 1'b1;
        end else if (rd) begin
            build_data          = shadow[dword];
            row_exp[n_rows]     = build_data;
            row_on_data[n_rows] = 1'b1;
        end else begin
            row_exp[n_rows]     = shadow[iword];
            row_on_data[n_rows] = 1'b0;
        end
        n_rows++;
    endtask

    task automatic build_table();
        for (int i = 0; i < MEM_DEPTH; i++) begin
            shadow[i] = preload_word(i);
        end
        n_rows     = 0;
        build_data = '0;
        // fetches after reset
        add_row(1'b0, 1'b0, 0, 0);
        add_row(1'b0, 1'b0, 0, 1);
        add_row(1'b0, 1'b0, 0, 2);
        add_row(1'b0, 1'b0, 0, 3);
        // loads of untouched words
        add_row(1'b1, 1'b0, 5, 3);
        add_row(1'b1, 1'b0, 15, 3);
        // store then load back
        add_row(1'b0, 1'b1, 7, 3);
        add_row(1'b1, 1'b0, 7, 3);
        add_row(1'b1, 1'b0, 6, 3);
        add_row(1'b0, 1'b0, 0, 7);
        // store, load and fetch all pending
        add_row(1'b1, 1'b1, 9, 2);
        add_row(1'b1, 1'b0, 9, 2);
        add_row(1'b0, 1'b0, 9, 2);
        // more stores mixed with fetch and load
        add_row(1'b0, 1'b1, 0, 2);
        add_row(1'b0, 1'b0, 0, 0);
        add_row(1'b0, 1'b1, 12, 0);
        add_row(1'b1, 1'b0, 12, 0);
        add_row(1'b1, 1'b0, 13, 0);
    endtask

    // counts falling edges until the expected hit shows up
    task automatic wait_for_hit(input logic on_data, output int waited);
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
            assert (!(on_data ? i_hit : d_hit)) else begin
                fail_now($sformatf("wrong hit output pulsed at %0t", $time));
            end
        end while (!(on_data ? d_hit : i_hit) && waited <= MEM_LATENCY + 2);
        assert (on_data ? d_hit : i_hit) else begin
            fail_now($sformatf("no hit within %0d cycles of the request", waited));
        end
        assert (waited == MEM_LATENCY + 2) else begin
            fail_now($sformatf("access completed after %0d cycles instead of %0d",
                               waited, MEM_LATENCY + 2));
        end
    endtask

    // run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            fail_now($sformatf("timeout after %0d cycles before the table finished", cycles));
        end
    end

    initial begin
        logic [data_width-1:0] last_instr;
        logic [data_width-1:0] last_data;
        int                    waited;
        clk                 = 1'b0;
        rst                 = 1'b1;
        memread             = 1'b0;
        memwrite            = 1'b0;
        data_to_write       = '0;
        instruction_address = '0;
        data_address        = '0;
        build_table();
        cycle_limit = n_rows * (MEM_LATENCY + 4) + RESET_CYCLES + 50;

        repeat (RESET_CYCLES) @(negedge clk);
        check_word("i_hit_o", '0, i_hit);
        check_word("d_hit_o", '0, d_hit);
        check_word("instruction_o", '0, instruction);
        check_word("data_read_o", '0, data_read);
        rst        = 1'b0;
        last_instr = '0;
        last_data  = '0;

        for (int r = 0; r < n_rows; r++) begin
            memread             = row_rd[r];
            memwrite            = row_wr[r];
            data_address        = row_daddr[r];
            data_to_write       = row_wdata[r];
            instruction_address = row_iaddr[r];
            wait_for_hit(row_on_data[r], waited);
            if (row_on_data[r]) begin
                check_word("data_read_o", row_exp[r], data_read);
                check_word("instruction_o", last_instr, instruction);  // held
                last_data = row_exp[r];
            end else begin
                check_word("instruction_o", row_exp[r], instruction);
                check_word("data_read_o", last_data, data_read);
                last_instr = row_exp[r];
            end
            memread  = 1'b0;  // cpu drops the request in the hit cycle
            memwrite = 1'b0;
            @(negedge clk);
            // hits are single-cycle pulses
            check_word("i_hit_o", '0, i_hit);
            check_word("d_hit_o", '0, d_hit);
        end

        $display("STATUS: PASS");
        $finish;
    end

endmodule

/* mem_init.hex */
// one 32-bit word per line, line i holds memory word i
A5000000
A5000001
A5000002
A5000003
A5000004
A5000005
A5000006
A5000007
A5000008
A5000009
A500000A
A500000B
A500000C
A500000D
A500000E
A500000F

/* project.f */
bus_pkg.sv
mem_req_pkg.sv
bus_if.sv
request_unit.sv
bus_bridge.sv
word_sram.sv
mem_subsys_top.sv
tb_mem_subsys.sv

/* Bender.yml */
package:
  name: mem_subsys

sources:
  - files:
      - bus_pkg.sv
      - mem_req_pkg.sv
      - bus_if.sv
      - request_unit.sv
      - bus_bridge.sv
      - word_sram.sv
      - mem_subsys_top.sv
  - target: test
    files:
      - tb_mem_subsys.sv
